// File: src/accel_macros.svh
// Shared sizing constants for the accelerator command path
// Include wherever byte, word, buffer or packet sizes are needed

`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

// Data widths
`define ACCEL_BYTE_W 8
`define ACCEL_LANES 4
`define ACCEL_WORD_W (`ACCEL_BYTE_W * `ACCEL_LANES)

// Operand buffer geometry, depth must equal 2**AW
`define ACCEL_BUF_DEPTH 64
`define ACCEL_BUF_AW 6

// Host protocol framing
// Packet is cmd, addr lo, addr hi, data 0..3
`define ACCEL_PKT_BYTES 7
// Response is cmd echo plus four data bytes
`define ACCEL_RSP_BYTES 5

`endif

// File: src/accel_cmd_pkg.sv
// Host protocol types: command codes, received packet and response request
// Imported by the packet decoder and the top level

`default_nettype none

`include "accel_macros.svh"

package accel_cmd_pkg;

    // ==================================================
    // Command codes, high nibble of the command byte
    // ==================================================
    typedef enum logic [3:0] {
        CMD_CSR_WR   = 4'h0,
        CMD_CSR_RD   = 4'h1,
        CMD_BUF_WR_A = 4'h2,
        CMD_BUF_WR_B = 4'h3,
        CMD_START    = 4'h5,
        CMD_ABORT    = 4'h6,
        CMD_STATUS   = 4'h7
    } host_cmd_e;

    // ==================================================
    // Assembled seven-byte packet
    // ==================================================
    // Address and data both arrive low byte first
    typedef struct packed {
        logic [`ACCEL_BYTE_W-1:0]   cmd;
        logic [2*`ACCEL_BYTE_W-1:0] addr;
        logic [`ACCEL_WORD_W-1:0]   data;
    } host_packet_t;

    // Reply request toward the byte serializer
    typedef struct packed {
        logic [`ACCEL_BYTE_W-1:0] cmd;
        logic [`ACCEL_WORD_W-1:0] data;
    } rsp_req_t;

endpackage

`default_nettype wire

// File: src/accel_core_pkg.sv
// Core types: engine states, buffer write bundle and register map
// Imported by the decoder, the MAC engine and the top level

`default_nettype none

`include "accel_macros.svh"

package accel_core_pkg;

    // ==================================================
    // Dot-product engine sequencer
    // ==================================================
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        DRAIN  = 2'd2,
        FINISH = 2'd3
    } engine_state_e;

    // One word write into either operand buffer
    typedef struct packed {
        logic                      we_a;
        logic                      we_b;
        logic [`ACCEL_BUF_AW-1:0]  addr;
        logic [`ACCEL_WORD_W-1:0]  data;
    } buf_wr_t;

    // ==================================================
    // Register addresses
    // ==================================================
    // RESULT and STATUS are read-only
    typedef enum logic [2*`ACCEL_BYTE_W-1:0] {
        CSR_LEN    = 16'h0000,
        CSR_RESULT = 16'h0001,
        CSR_STATUS = 16'h0002
    } csr_addr_e;

endpackage

`default_nettype wire

// File: src/packet_rx.sv
// Host packet receiver and command decoder
// Collects seven strobed bytes, then on the following cycle issues buffer
// writes, engine control pulses, length updates and response requests

`timescale 1ns/1ps
`default_nettype none

`include "accel_macros.svh"

module packet_rx (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`ACCEL_BYTE_W-1:0]   i_rx_data,
    input  wire logic                       i_rx_valid,
    input  wire logic [`ACCEL_WORD_W-1:0]   i_result,
    input  wire logic                       i_busy,
    input  wire logic                       i_done,
    output accel_core_pkg::buf_wr_t         o_buf_wr,
    output logic                            o_start,
    output logic                            o_abort,
    output logic [`ACCEL_BUF_AW:0]          o_len,
    output logic                            o_rsp_valid,
    output accel_cmd_pkg::rsp_req_t         o_rsp
);

    import accel_cmd_pkg::*;
    import accel_core_pkg::*;

    localparam int CNT_W = $clog2(`ACCEL_PKT_BYTES);

    logic [CNT_W-1:0]          byte_cnt_q;
    logic                      pkt_vld_q;
    host_packet_t              pkt_q;
    host_cmd_e                 cmd;
    logic [`ACCEL_BUF_AW-1:0]  len_q;
    logic                      done_seen_q;
    logic [`ACCEL_WORD_W-1:0]  status_word;

    // ==================================================
    // Byte assembly
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt_q <= '0;
            pkt_vld_q  <= 1'b0;
        end else begin
            pkt_vld_q <= 1'b0;
            if (i_rx_valid) begin
                if (byte_cnt_q == CNT_W'(`ACCEL_PKT_BYTES - 1)) begin
                    byte_cnt_q <= '0;
                    pkt_vld_q  <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            case (byte_cnt_q)
                CNT_W'(0): pkt_q.cmd <= i_rx_data;
                CNT_W'(1): pkt_q.addr[7:0] <= i_rx_data;
                CNT_W'(2): pkt_q.addr[15:8] <= i_rx_data;
                // Data bytes shift down so byte 0 ends in the low lane
                default: pkt_q.data <= {i_rx_data, pkt_q.data[`ACCEL_WORD_W-1:`ACCEL_BYTE_W]};
            endcase
        end
    end

    assign cmd = host_cmd_e'(pkt_q.cmd[`ACCEL_BYTE_W-1:4]);

    // ==================================================
    // Register file and status
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            len_q       <= `ACCEL_BUF_AW'(1);
            done_seen_q <= 1'b0;
        end else begin
            if (pkt_vld_q && cmd == CMD_CSR_WR && pkt_q.addr == CSR_LEN) begin
                len_q <= pkt_q.data[`ACCEL_BUF_AW-1:0];
            end
            // START wins over a coincident done
            if (o_start) begin
                done_seen_q <= 1'b0;
            end else if (i_done) begin
                done_seen_q <= 1'b1;
            end
        end
    end

    // Zero length runs the full buffer
    assign o_len = (len_q == '0) ? (`ACCEL_BUF_AW+1)'(`ACCEL_BUF_DEPTH) : {1'b0, len_q};

    always_comb begin
        status_word    = '0;
        status_word[0] = i_busy;
        status_word[1] = done_seen_q;
    end

    // Command outputs
    assign o_buf_wr.we_a = pkt_vld_q && (cmd == CMD_BUF_WR_A);
    assign o_buf_wr.we_b = pkt_vld_q && (cmd == CMD_BUF_WR_B);
    assign o_buf_wr.addr = pkt_q.addr[`ACCEL_BUF_AW-1:0];
    assign o_buf_wr.data = pkt_q.data;

    assign o_start = pkt_vld_q && (cmd == CMD_START) && !i_busy;
    assign o_abort = pkt_vld_q && (cmd == CMD_ABORT);

    assign o_rsp_valid = pkt_vld_q && ((cmd == CMD_CSR_RD) || (cmd == CMD_STATUS));
    assign o_rsp.cmd   = pkt_q.cmd;

    always_comb begin
        if (cmd == CMD_STATUS) begin
            o_rsp.data = status_word;
        end else begin
            case (pkt_q.addr)
                CSR_LEN:    o_rsp.data = `ACCEL_WORD_W'(len_q);
                CSR_RESULT: o_rsp.data = i_result;
                CSR_STATUS: o_rsp.data = status_word;
                default:    o_rsp.data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/operand_buffer.sv
// Activation (A) and weight (B) operand memories
// Separate write enables, one shared read address; both words return
// one cycle after the read enable

`timescale 1ns/1ps
`default_nettype none

`include "accel_macros.svh"

module operand_buffer (
    input  wire logic                       clk,
    input  wire accel_core_pkg::buf_wr_t    i_buf_wr,
    input  wire logic                       i_rd_en,
    input  wire logic [`ACCEL_BUF_AW-1:0]   i_rd_addr,
    output logic [`ACCEL_WORD_W-1:0]        o_a_word,
    output logic [`ACCEL_WORD_W-1:0]        o_b_word
);

    localparam int N_BANKS = 2;

    // Bank 0 is A, bank 1 is B
    logic [N_BANKS-1:0] bank_we;

    assign bank_we = {i_buf_wr.we_b, i_buf_wr.we_a};

    // ==================================================
    // Memory banks
    // ==================================================
    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        logic [`ACCEL_WORD_W-1:0] mem [`ACCEL_BUF_DEPTH];
        logic [`ACCEL_WORD_W-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (bank_we[b]) begin
                mem[i_buf_wr.addr] <= i_buf_wr.data;
            end
            // Read holds its last value between reads
            if (i_rd_en) begin
                rd_q <= mem[i_rd_addr];
            end
        end
    end

    assign o_a_word = g_bank[0].rd_q;
    assign o_b_word = g_bank[1].rd_q;

endmodule

`default_nettype wire

// File: src/mac_engine.sv
// Four-lane int8 dot-product engine
// Reads L word pairs back to back, accumulates their lane products and
// publishes the sum with a done pulse L+2 cycles after start

`timescale 1ns/1ps
`default_nettype none

`include "accel_macros.svh"

module mac_engine (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       i_start,
    input  wire logic                       i_abort,
    input  wire logic [`ACCEL_BUF_AW:0]     i_len,
    input  wire logic [`ACCEL_WORD_W-1:0]   i_a_word,
    input  wire logic [`ACCEL_WORD_W-1:0]   i_b_word,
    output logic                            o_rd_en,
    output logic [`ACCEL_BUF_AW-1:0]        o_rd_addr,
    output logic [`ACCEL_WORD_W-1:0]        o_result,
    output logic                            o_busy,
    output logic                            o_done
);

    import accel_core_pkg::*;

    localparam int BW = `ACCEL_BYTE_W;

    engine_state_e                  state_q;
    logic [`ACCEL_BUF_AW-1:0]       addr_q;
    logic [`ACCEL_BUF_AW:0]         len_q;
    logic                           rd_vld_q;
    logic [`ACCEL_WORD_W-1:0]       acc_q;
    logic signed [2*BW-1:0]         prod [`ACCEL_LANES];
    logic signed [`ACCEL_WORD_W-1:0] dot;
    logic                           last_rd;
    logic                           go;

    assign go      = i_start && !o_busy;
    assign last_rd = ({1'b0, addr_q} == len_q - 1'b1);

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            rd_vld_q <= 1'b0;
            o_result <= '0;
        end else begin
            rd_vld_q <= o_rd_en;
            if (i_abort) begin
                state_q <= IDLE;
            end else begin
                case (state_q)
                    IDLE:   if (go) state_q <= RUN;
                    RUN:    if (last_rd) state_q <= DRAIN;
                    DRAIN: begin
                        // Last word lands here
                        state_q  <= FINISH;
                        o_result <= acc_q + dot;
                    end
                    FINISH: state_q <= go ? RUN : IDLE;
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    assign o_rd_en   = (state_q == RUN);
    assign o_rd_addr = addr_q;
    assign o_busy    = (state_q == RUN) || (state_q == DRAIN);
    assign o_done    = (state_q == FINISH);

    // ==================================================
    // Datapath
    // ==================================================
    always_comb begin
        dot = '0;
        for (int i = 0; i < `ACCEL_LANES; i++) begin
            prod[i] = $signed(i_a_word[i*BW +: BW]) * $signed(i_b_word[i*BW +: BW]);
            dot     = dot + prod[i];
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            addr_q <= '0;
            len_q  <= i_len;
            acc_q  <= '0;
        end else begin
            if (o_rd_en) begin
                addr_q <= addr_q + 1'b1;
            end
            if (rd_vld_q) begin
                acc_q <= acc_q + dot;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/response_tx.sv
// Response serializer
// Latches one request while idle and sends the command byte, then the
// data word low byte first, advancing on each edge with ready high

`timescale 1ns/1ps
`default_nettype none

`include "accel_macros.svh"

module response_tx (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       i_rsp_valid,
    input  wire accel_cmd_pkg::rsp_req_t    i_rsp,
    input  wire logic                       i_tx_ready,
    output logic [`ACCEL_BYTE_W-1:0]        o_tx_data,
    output logic                            o_tx_valid
);

    localparam int IDX_W = $clog2(`ACCEL_RSP_BYTES);
    localparam int SH_W  = `ACCEL_RSP_BYTES * `ACCEL_BYTE_W;

    logic              active_q;
    logic [IDX_W-1:0]  idx_q;
    logic [SH_W-1:0]   shift_q;
    logic              accept;

    assign accept = active_q && i_tx_ready;

    // ==================================================
    // Byte counter
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            idx_q    <= '0;
        end else if (!active_q) begin
            // Requests during a transfer are dropped
            if (i_rsp_valid) begin
                active_q <= 1'b1;
                idx_q    <= '0;
            end
        end else if (accept) begin
            if (idx_q == IDX_W'(`ACCEL_RSP_BYTES - 1)) begin
                active_q <= 1'b0;
            end
            idx_q <= idx_q + 1'b1;
        end
    end

    // Header sits in the low byte, data bytes above it
    always_ff @(posedge clk) begin
        if (!active_q && i_rsp_valid) begin
            shift_q <= {i_rsp.data, i_rsp.cmd};
        end else if (accept) begin
            shift_q <= shift_q >> `ACCEL_BYTE_W;
        end
    end

    assign o_tx_valid = active_q;
    assign o_tx_data  = shift_q[`ACCEL_BYTE_W-1:0];

endmodule

`default_nettype wire

// File: src/accel_top.sv
// Accelerator top level for the byte-stream command path
// Receiver feeds the operand buffers and MAC engine; replies go out
// through the response serializer

`timescale 1ns/1ps
`default_nettype none

`include "accel_macros.svh"

module accel_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`ACCEL_BYTE_W-1:0]   i_rx_data,
    input  wire logic                       i_rx_valid,
    input  wire logic                       i_tx_ready,
    output logic [`ACCEL_BYTE_W-1:0]        o_tx_data,
    output logic                            o_tx_valid,
    output logic                            o_busy,
    output logic                            o_done
);

    import accel_cmd_pkg::*;
    import accel_core_pkg::*;

    // ==================================================
    // Internal wiring
    // ==================================================
    buf_wr_t                   buf_wr;
    rsp_req_t                  rsp;
    logic                      rsp_valid;
    logic                      start;
    logic                      abort;
    logic [`ACCEL_BUF_AW:0]    len;
    logic                      rd_en;
    logic [`ACCEL_BUF_AW-1:0]  rd_addr;
    logic [`ACCEL_WORD_W-1:0]  a_word;
    logic [`ACCEL_WORD_W-1:0]  b_word;
    logic [`ACCEL_WORD_W-1:0]  result;

    packet_rx packet_rx_i (
        .clk(clk), .rst_n(rst_n),
        .i_rx_data(i_rx_data), .i_rx_valid(i_rx_valid),
        .i_result(result), .i_busy(o_busy), .i_done(o_done),
        .o_buf_wr(buf_wr), .o_start(start), .o_abort(abort), .o_len(len),
        .o_rsp_valid(rsp_valid), .o_rsp(rsp)
    );

    operand_buffer operand_buffer_i (
        .clk(clk), .i_buf_wr(buf_wr),
        .i_rd_en(rd_en), .i_rd_addr(rd_addr),
        .o_a_word(a_word), .o_b_word(b_word)
    );

    mac_engine mac_engine_i (
        .clk(clk), .rst_n(rst_n),
        .i_start(start), .i_abort(abort), .i_len(len),
        .i_a_word(a_word), .i_b_word(b_word),
        .o_rd_en(rd_en), .o_rd_addr(rd_addr), .o_result(result),
        .o_busy(o_busy), .o_done(o_done)
    );

    response_tx response_tx_i (
        .clk(clk), .rst_n(rst_n),
        .i_rsp_valid(rsp_valid), .i_rsp(rsp), .i_tx_ready(i_tx_ready),
        .o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid)
    );

endmodule

`default_nettype wire

// File: test/accel_tests.svh
// Packet driver, response collector, reference model and directed tests
// Included inside the body of the accel_tb module

`ifndef ACCEL_TESTS_SVH
`define ACCEL_TESTS_SVH

// ==================================================
// Reference model
// ==================================================
logic [31:0] model_a [`ACCEL_BUF_DEPTH];
logic [31:0] model_b [`ACCEL_BUF_DEPTH];
logic [5:0]  model_len;
logic [31:0] last_result;

// Sum of signed int8 lane products over the first words, wrapping in 32 bits
function automatic logic [31:0] dot_reference(input int words);
    int sum;
    int prod;
    logic signed [7:0] a;
    logic signed [7:0] b;
    sum = 0;
    for (int w = 0; w < words; w++) begin
        for (int i = 0; i < `ACCEL_LANES; i++) begin
            a    = model_a[w][i*8 +: 8];
            b    = model_b[w][i*8 +: 8];
            prod = a * b;
            sum  = sum + prod;
        end
    end
    return sum;
endfunction

// Bytes go out command first, then address and data low byte first
task automatic send_packet(input logic [7:0] cmd, input logic [15:0] addr,
                           input logic [31:0] data);
    logic [55:0] bytes;
    bytes = {data, addr, cmd};
    for (int i = 0; i < `ACCEL_PKT_BYTES; i++) begin
        repeat (next_rand() % 3) begin
            @(posedge clk);
            i_rx_valid <= 1'b0;
        end
        @(posedge clk);
        i_rx_data  <= bytes[i*8 +: 8];
        i_rx_valid <= 1'b1;
    end
    @(posedge clk);
    i_rx_valid <= 1'b0;
endtask

// Ready is high with a chance of one in stall on each cycle
task automatic collect_response(input int stall, output logic [39:0] word);
    int n;
    int waited;
    n      = 0;
    waited = 0;
    word   = '0;
    while (n < `ACCEL_RSP_BYTES) begin
        @(posedge clk);
        i_tx_ready <= ((next_rand() % stall) == 0);
        @(negedge clk);
        if (o_tx_valid && i_tx_ready) begin
            word[n*8 +: 8] = o_tx_data;
            n++;
        end
        waited++;
        if (waited > 1000) begin
            $display("No complete response came from the DUT within 1000 cycles");
            stop_with_failure();
        end
    end
    @(posedge clk);
    i_tx_ready <= 1'b0;
endtask

task automatic query(input string name, input logic [7:0] cmd, input logic [15:0] addr,
                     input logic [31:0] exp_data, input int stall);
    logic [39:0] rsp;
    send_packet(cmd, addr, 32'h0);
    collect_response(stall, rsp);
    check_equal(name, {exp_data, cmd}, rsp);
endtask

task automatic set_length(input logic [31:0] value);
    send_packet({CMD_CSR_WR, 4'h0}, CSR_LEN, value);
    model_len = value[5:0];
endtask

// START, then count cycles from the START pulse to o_done
task automatic run_and_check(input string name);
    int cycles;
    int words;
    words = (model_len == 0) ? `ACCEL_BUF_DEPTH : model_len;
    send_packet({CMD_START, 4'h0}, 16'h0, 32'h0);
    cycles = 0;
    @(negedge clk);
    while (!o_done) begin
        @(negedge clk);
        cycles++;
        if (cycles == 1) begin
            check_equal({name, " busy"}, 1, o_busy);
        end
        if (cycles > 2 * RUN_CYCLES) begin
            $display("The engine never raised o_done after START");
            stop_with_failure();
        end
    end
    check_equal({name, " done cycle"}, words + 2, cycles);
    check_equal({name, " busy at done"}, 0, o_busy);
    @(negedge clk);
    check_equal({name, " done pulse"}, 0, o_done);
    last_result = dot_reference(words);
    query({name, " result"}, {CMD_CSR_RD, 4'h0}, CSR_RESULT, last_result, 2);
    query({name, " status"}, {CMD_STATUS, 4'h0}, 16'h0, 32'h2, 2);
endtask

// ==================================================
// Directed tests
// ==================================================
task automatic verify_reset_state();
    model_len = 6'd1;
    @(negedge clk);
    check_equal("reset busy", 0, o_busy);
    check_equal("reset done", 0, o_done);
    check_equal("reset tx valid", 0, o_tx_valid);
    query("reset status", {CMD_STATUS, 4'h3}, 16'h0, 32'h0, 2);
    query("reset length", {CMD_CSR_RD, 4'h0}, CSR_LEN, 32'h1, 2);
endtask

task automatic exercise_length_register();
    logic [31:0] values [5];
    values    = '{32'h25, 32'hFFFF_FFFF, 32'h40, 32'h0, 32'h0};
    values[3] = next_rand();
    for (int i = 0; i < 5; i++) begin
        set_length(values[i]);
        query("length readback", {CMD_CSR_RD, 4'h0}, CSR_LEN, {26'h0, values[i][5:0]}, 2);
    end
endtask

task automatic compute_dot_products();
    logic [5:0] len;
    for (int w = 0; w < `ACCEL_BUF_DEPTH; w++) begin
        model_a[w] = next_rand();
        model_b[w] = next_rand();
        send_packet({CMD_BUF_WR_A, 4'h0}, 16'(w), model_a[w]);
        send_packet({CMD_BUF_WR_B, 4'h0}, 16'(w), model_b[w]);
    end
    // Length is still 0 here, so the first run covers all 64 words
    run_and_check("dot full");
    len = 6'(next_rand() % 63 + 1);
    set_length({26'h0, len});
    run_and_check("dot random");
endtask

task automatic abort_long_run();
    logic seen_done;
    seen_done = 1'b0;
    set_length(32'h0);
    send_packet({CMD_START, 4'h0}, 16'h0, 32'h0);
    repeat (2) @(negedge clk);
    check_equal("abort busy before", 1, o_busy);
    fork
        send_packet({CMD_ABORT, 4'h0}, 16'h0, 32'h0);
        repeat (2 * RUN_CYCLES) begin
            @(negedge clk);
            if (o_done) seen_done = 1'b1;
        end
    join
    check_equal("abort no done", 0, seen_done);
    check_equal("abort busy after", 0, o_busy);
    query("abort result", {CMD_CSR_RD, 4'h0}, CSR_RESULT, last_result, 2);
    query("abort status", {CMD_STATUS, 4'h0}, 16'h0, 32'h0, 2);
endtask

task automatic stretch_responses();
    query("stretched result", {CMD_CSR_RD, 4'h0}, CSR_RESULT, last_result, 8);
    query("stretched length", {CMD_CSR_RD, 4'h0}, CSR_LEN, {26'h0, model_len}, 8);
    @(negedge clk);
    check_equal("stretched tx idle", 0, o_tx_valid);
endtask

`endif

// File: test/accel_tb.sv
// Testbench for the accelerator byte-stream command path
// Drives packets into accel_top, collects responses and checks results and
// timing against a reference model; the directed tests are in the tests header

`timescale 1ns/1ps
`default_nettype none

`include "accel_macros.svh"

module accel_tb;

    import accel_cmd_pkg::*;
    import accel_core_pkg::*;

    localparam int CLK_HALF   = 50;
    localparam int RST_CYCLES = 16;

    // ==================================================
    // Watchdog budget
    // ==================================================
    // Worst case packet is seven bytes with two idle cycles before each
    localparam int PKT_CYCLES  = `ACCEL_PKT_BYTES * 3 + 1;
    localparam int RSP_CYCLES  = 100;
    localparam int RUN_CYCLES  = `ACCEL_BUF_DEPTH + 6;
    localparam int TEST_CYCLES = RST_CYCLES + 154 * PKT_CYCLES + 15 * RSP_CYCLES
                               + 4 * RUN_CYCLES + 100;
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

    logic                      clk;
    logic                      rst_n;
    logic [`ACCEL_BYTE_W-1:0]  i_rx_data;
    logic                      i_rx_valid;
    logic                      i_tx_ready;
    logic [`ACCEL_BYTE_W-1:0]  o_tx_data;
    logic                      o_tx_valid;
    logic                      o_busy;
    logic                      o_done;
    logic [31:0]               rng_state;

    accel_top accel_top_i (
        .clk(clk), .rst_n(rst_n),
        .i_rx_data(i_rx_data), .i_rx_valid(i_rx_valid), .i_tx_ready(i_tx_ready),
        .o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid),
        .o_busy(o_busy), .o_done(o_done)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // xorshift32 step on the shared generator state
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    `include "accel_tests.svh"

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the tests did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        stop_with_failure();
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        rng_state  = 32'd15308;
        rst_n      = 1'b0;
        i_rx_data  = '0;
        i_rx_valid = 1'b0;
        i_tx_ready = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        verify_reset_state();
        exercise_length_register();
        compute_dot_products();
        abort_long_run();
        stretch_responses();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
+incdir+test
src/accel_cmd_pkg.sv
src/accel_core_pkg.sv
src/packet_rx.sv
src/operand_buffer.sv
src/mac_engine.sv
src/response_tx.sv
src/accel_top.sv
test/accel_tb.sv
